// ==== lsu_ctrl_top.f ====
src/lsu_pkg.sv
src/lsu_rsp_if.sv
src/lsu_outs_fifo.sv
src/lsu_excl_monitor.sv
src/lsu_ctrl.sv
src/lsu_wbck_fmt.sv
src/lsu_ctrl_top.sv
verif/lsu_tgt_model.sv
verif/tb_lsu_ctrl_top.sv

// ==== verif/tb_lsu_ctrl_top.sv ====
`timescale 1ns/1ps

module tb_lsu_ctrl_top import lsu_pkg::*; ();

  localparam logic [ADDR_W-1:0] DTCM_BASE = 32'h8000_0000;
  localparam logic [ADDR_W-1:0] BIU_BASE  = 32'h2000_0000;
  localparam logic [ADDR_W-1:0] ERR_BASE  = 32'hF000_0000;
  localparam int N_RAND      = 200;
  localparam int N_CMDS      = 48 + 10 + 6 + 9 + 2 + N_RAND;
  localparam int TIMEOUT_CYC = 20 * N_CMDS + 200;

  typedef struct packed {
    logic [XLEN-1:0]   wdat;
    logic [ITAG_W-1:0] itag;
    logic              err;
    logic              ld;
    logic              st;
    logic [ADDR_W-1:0] addr;
  } exp_t;

  logic i_clk, i_reset, i_commit_flush;
  logic i_agu_cmd_valid, o_agu_cmd_ready, i_agu_cmd_read, i_agu_cmd_excl, i_agu_cmd_usign;
  logic [ADDR_W-1:0] i_agu_cmd_addr;
  logic [XLEN-1:0] i_agu_cmd_wdata;
  logic [WMASK_W-1:0] i_agu_cmd_wmask;
  logic [1:0] i_agu_cmd_size;
  logic [ITAG_W-1:0] i_agu_cmd_itag;
  logic o_dtcm_cmd_valid, i_dtcm_cmd_ready, o_dtcm_cmd_read;
  logic [DTCM_ADDR_W-1:0] o_dtcm_cmd_addr;
  logic [XLEN-1:0] o_dtcm_cmd_wdata, i_dtcm_rsp_rdata;
  logic [WMASK_W-1:0] o_dtcm_cmd_wmask;
  logic [1:0] o_dtcm_cmd_size;
  logic i_dtcm_rsp_valid, o_dtcm_rsp_ready, i_dtcm_rsp_err;
  logic o_biu_cmd_valid, i_biu_cmd_ready, o_biu_cmd_read;
  logic [ADDR_W-1:0] o_biu_cmd_addr;
  logic [XLEN-1:0] o_biu_cmd_wdata, i_biu_rsp_rdata;
  logic [WMASK_W-1:0] o_biu_cmd_wmask;
  logic [1:0] o_biu_cmd_size;
  logic i_biu_rsp_valid, o_biu_rsp_ready, i_biu_rsp_err;
  logic o_lsu_valid, i_lsu_ready, o_lsu_wbck_err, o_lsu_cmt_ld, o_lsu_cmt_st;
  logic [XLEN-1:0] o_lsu_wbck_wdat;
  logic [ITAG_W-1:0] o_lsu_wbck_itag;
  logic [ADDR_W-1:0] o_lsu_cmt_badaddr;

  // Expected write-backs in issue order, plus shadow state of both targets
  exp_t              exp_q [$];
  logic [XLEN-1:0]   shadow_dtcm [logic [ADDR_W-1:0]];
  logic [XLEN-1:0]   shadow_biu [logic [ADDR_W-1:0]];
  logic              resv_valid;
  logic [ADDR_W-1:0] resv_addr;
  logic [ITAG_W-1:0] next_itag;
  int                cyc_cnt;
  int                dtcm_outs;
  int                biu_outs;

  lsu_ctrl_top i_dut (.*);

  lsu_tgt_model #(.AW(DTCM_ADDR_W), .ERR_EN(1'b0)) u_dtcm (
    .i_clk (i_clk), .i_reset (i_reset),
    .i_cmd_valid (o_dtcm_cmd_valid), .o_cmd_ready (i_dtcm_cmd_ready),
    .i_cmd_addr (o_dtcm_cmd_addr), .i_cmd_read (o_dtcm_cmd_read),
    .i_cmd_wdata (o_dtcm_cmd_wdata), .i_cmd_wmask (o_dtcm_cmd_wmask),
    .o_rsp_valid (i_dtcm_rsp_valid), .i_rsp_ready (o_dtcm_rsp_ready),
    .o_rsp_err (i_dtcm_rsp_err), .o_rsp_rdata (i_dtcm_rsp_rdata)
  );

  lsu_tgt_model #(.AW(ADDR_W), .ERR_EN(1'b1), .ERR_BASE(ERR_BASE)) u_biu (
    .i_clk (i_clk), .i_reset (i_reset),
    .i_cmd_valid (o_biu_cmd_valid), .o_cmd_ready (i_biu_cmd_ready),
    .i_cmd_addr (o_biu_cmd_addr), .i_cmd_read (o_biu_cmd_read),
    .i_cmd_wdata (o_biu_cmd_wdata), .i_cmd_wmask (o_biu_cmd_wmask),
    .o_rsp_valid (i_biu_rsp_valid), .i_rsp_ready (o_biu_rsp_ready),
    .o_rsp_err (i_biu_rsp_err), .o_rsp_rdata (i_biu_rsp_rdata)
  );

  always #2 i_clk = ~i_clk;

  //////////////////////////////////////////////////
  // Reference model

  function automatic logic [XLEN-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return (a * 32'h9E37_79B1) ^ 32'h5A3C_C3A5;
  endfunction

  function automatic logic [XLEN-1:0] read_shadow(input logic is_biu,
                                                  input logic [ADDR_W-1:0] key);
    if (is_biu) begin
      return shadow_biu.exists(key) ? shadow_biu[key] : fill_word(key);
    end
    return shadow_dtcm.exists(key) ? shadow_dtcm[key] : fill_word(key);
  endfunction

  // SC returns 0 on success, plain stores return 0, loads are lane-shifted and extended
  function automatic logic [XLEN-1:0] predict_wdat(input logic [XLEN-1:0] word,
      input logic [ADDR_W-1:0] addr, input lsu_size_e size, input logic usign,
      input logic rd, input logic excl, input logic sc_ok);
    logic [XLEN-1:0] sh;
    if (!rd) begin
      return (excl && !sc_ok) ? XLEN'(1) : '0;
    end
    sh = word >> {addr[1:0], 3'b000};
    case (size)
      LSU_SIZE_BYTE: return {{(XLEN-8){~usign & sh[7]}}, sh[7:0]};
      LSU_SIZE_HALF: return {{(XLEN-16){~usign & sh[15]}}, sh[15:0]};
      default:       return sh;
    endcase
  endfunction

  task automatic record_accept(input logic [ADDR_W-1:0] addr, input logic rd,
      input logic [XLEN-1:0] wdata, input logic [WMASK_W-1:0] wmask, input lsu_size_e size,
      input logic excl, input logic usign, input logic [ITAG_W-1:0] itag);
    logic              is_biu;
    logic [ADDR_W-1:0] key;
    logic [XLEN-1:0]   word;
    logic              err;
    logic              sc_ok;
    exp_t              exp;
    is_biu = (addr[DTCM_REGION_HI:DTCM_REGION_LO] != DTCM_REGION_VAL);
    key    = is_biu ? {addr[ADDR_W-1:2], 2'b00} : ADDR_W'({addr[DTCM_ADDR_W-1:2], 2'b00});
    err    = is_biu && (addr >= ERR_BASE);
    word   = read_shadow(is_biu, key);
    sc_ok  = excl && !rd && resv_valid && (resv_addr == addr);
    exp.wdat = predict_wdat(err ? '0 : word, addr, size, usign, rd, excl, sc_ok);
    exp.itag = itag;
    exp.err  = err;
    exp.ld   = rd;
    exp.st   = !rd;
    exp.addr = addr;
    exp_q.push_back(exp);
    // Failed SC and bus errors leave memory alone
    if (!rd && !err && (!excl || sc_ok)) begin
      for (int b = 0; b < WMASK_W; b++) begin
        if (wmask[b]) begin
          word[8*b +: 8] = wdata[8*b +: 8];
        end
      end
      if (is_biu) begin
        shadow_biu[key] = word;
      end else begin
        shadow_dtcm[key] = word;
      end
    end
    if (rd && excl) begin
      resv_valid = 1'b1;
      resv_addr  = addr;
    end else if (!rd && resv_valid && (resv_addr == addr)) begin
      resv_valid = 1'b0;
    end
  endtask

  //////////////////////////////////////////////////
  // Checking

  task automatic abort_run();
    $display("CHECKS FAILED");
    $fatal(1);
  endtask

  task automatic check_wdat(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input logic [ADDR_W-1:0] addr);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: wbck_wdat %h, expected %h (addr %h)", $realtime, got, exp,
               addr);
      abort_run();
    end
  endtask

  task automatic check_itag(input logic [ITAG_W-1:0] got, input logic [ITAG_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: wbck_itag %0d, expected %0d", $realtime, got, exp);
      abort_run();
    end
  endtask

  task automatic check_flags(input logic got_err, input logic got_ld, input logic got_st,
                             input logic exp_err, input logic exp_ld, input logic exp_st);
    if ({got_err, got_ld, got_st} !== {exp_err, exp_ld, exp_st}) begin
      $display("CHECK FAILED at %0t: err/ld/st %b%b%b, expected %b%b%b", $realtime,
               got_err, got_ld, got_st, exp_err, exp_ld, exp_st);
      abort_run();
    end
  endtask

  task automatic check_badaddr(input logic [ADDR_W-1:0] got, input logic [ADDR_W-1:0] exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: cmt_badaddr %h, expected %h", $realtime, got, exp);
      abort_run();
    end
  endtask

  task automatic check_size(input logic [1:0] got, input lsu_size_e exp);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: cmd_size %0d, expected %0d", $realtime, got, exp);
      abort_run();
    end
  endtask

  //////////////////////////////////////////////////
  // Stimulus

  task automatic issue_cmd(input logic [ADDR_W-1:0] addr, input logic rd,
      input logic [XLEN-1:0] wdata, input logic [WMASK_W-1:0] wmask, input lsu_size_e size,
      input logic excl, input logic usign);
    logic is_biu;
    i_agu_cmd_valid = 1'b1;
    i_agu_cmd_addr  = addr;
    i_agu_cmd_read  = rd;
    i_agu_cmd_wdata = wdata;
    i_agu_cmd_wmask = wmask;
    i_agu_cmd_size  = size;
    i_agu_cmd_excl  = excl;
    i_agu_cmd_usign = usign;
    i_agu_cmd_itag  = next_itag;
    @(posedge i_clk);
    while (!o_agu_cmd_ready) begin
      @(posedge i_clk);
    end
    // Size must reach the target picked by the region decode
    is_biu = (addr[DTCM_REGION_HI:DTCM_REGION_LO] != DTCM_REGION_VAL);
    check_size(is_biu ? o_biu_cmd_size : o_dtcm_cmd_size, size);
    record_accept(addr, rd, wdata, wmask, size, excl, usign, next_itag);
    next_itag = next_itag + 1'b1;
    #0.5;
    i_agu_cmd_valid = 1'b0;
  endtask

  task automatic read_mem(input logic [ADDR_W-1:0] addr, input lsu_size_e size,
                          input logic usign);
    issue_cmd(addr, 1'b1, '0, '0, size, 1'b0, usign);
  endtask

  task automatic write_mem(input logic [ADDR_W-1:0] addr, input logic [XLEN-1:0] wdata,
                           input logic [WMASK_W-1:0] wmask);
    issue_cmd(addr, 1'b0, wdata, wmask, LSU_SIZE_WORD, 1'b0, 1'b0);
  endtask

  task automatic reserve(input logic [ADDR_W-1:0] addr);
    issue_cmd(addr, 1'b1, '0, '0, LSU_SIZE_WORD, 1'b1, 1'b0);
  endtask

  task automatic store_conditional(input logic [ADDR_W-1:0] addr,
                                   input logic [XLEN-1:0] wdata);
    issue_cmd(addr, 1'b0, wdata, '1, LSU_SIZE_WORD, 1'b1, 1'b0);
  endtask

  task automatic flush_commit();
    i_commit_flush = 1'b1;
    @(posedge i_clk);
    resv_valid = 1'b0;
    #0.5;
    i_commit_flush = 1'b0;
  endtask

  always @(posedge i_clk) begin : compare
    exp_t exp;
    if (!i_reset && o_lsu_valid && i_lsu_ready) begin
      if (exp_q.size() == 0) begin
        $display("Write-back at %0t with no access outstanding", $realtime);
        abort_run();
      end else begin
        exp = exp_q.pop_front();
        check_wdat(o_lsu_wbck_wdat, exp.wdat, exp.addr);
        check_itag(o_lsu_wbck_itag, exp.itag);
        check_flags(o_lsu_wbck_err, o_lsu_cmt_ld, o_lsu_cmt_st, exp.err, exp.ld, exp.st);
        check_badaddr(o_lsu_cmt_badaddr, exp.addr);
      end
    end
  end

  // A command to one target must never overlap accesses in flight at the other
  always @(posedge i_clk) begin
    if (i_reset) begin
      dtcm_outs = 0;
      biu_outs  = 0;
    end else begin
      if ((o_dtcm_cmd_valid && biu_outs != 0) || (o_biu_cmd_valid && dtcm_outs != 0)) begin
        $display("Command at %0t reached one target while the other had accesses in flight",
                 $realtime);
        abort_run();
      end
      if (o_dtcm_cmd_valid && i_dtcm_cmd_ready) dtcm_outs++;
      if (o_biu_cmd_valid && i_biu_cmd_ready) biu_outs++;
      if (i_dtcm_rsp_valid && o_dtcm_rsp_ready) dtcm_outs--;
      if (i_biu_rsp_valid && o_biu_rsp_ready) biu_outs--;
    end
  end

  // Random write-back back-pressure
  always @(posedge i_clk) begin
    #0.5;
    i_lsu_ready = i_reset ? 1'b0 : ($urandom_range(0, 3) != 0);
  end

  always @(posedge i_clk) begin
    cyc_cnt++;
    if (cyc_cnt >= TIMEOUT_CYC) begin
      $display("Run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("CHECKS FAILED");
      $fatal(1);
    end
  end

  initial begin
    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] addr;
    void'($urandom(32'h3f84_d628));
    i_clk = 1'b0;
    i_reset = 1'b1;
    i_commit_flush = 1'b0;
    i_agu_cmd_valid = 1'b0;
    i_agu_cmd_addr = '0;
    i_agu_cmd_read = 1'b0;
    i_agu_cmd_wdata = '0;
    i_agu_cmd_wmask = '0;
    i_agu_cmd_size = '0;
    i_agu_cmd_excl = 1'b0;
    i_agu_cmd_usign = 1'b0;
    i_agu_cmd_itag = '0;
    i_lsu_ready = 1'b0;
    resv_valid = 1'b0;
    resv_addr = '0;
    next_itag = '0;
    cyc_cnt = 0;
    repeat (10) @(posedge i_clk);
    #0.5;
    i_reset = 1'b0;

    // Every size, sign and byte offset in both regions
    for (int r = 0; r < 2; r++) begin
      for (int s = 0; s < 3; s++) begin
        for (int u = 0; u < 2; u++) begin
          for (int off = 0; off < 4; off++) begin
            read_mem((r != 0 ? BIU_BASE : DTCM_BASE) + 32'h40 + off, lsu_size_e'(s), u != 0);
          end
        end
      end
    end

    // Partial masks checked by reading the word back
    for (int r = 0; r < 2; r++) begin
      base = (r != 0 ? BIU_BASE : DTCM_BASE) + 32'h80;
      write_mem(base, 32'h1122_3344, 4'hF);
      write_mem(base, 32'hAABB_CCDD, 4'b0101);
      read_mem(base, LSU_SIZE_WORD, 1'b1);
      write_mem(base, 32'h5566_7788, 4'b1000);
      read_mem(base, LSU_SIZE_WORD, 1'b1);
    end

    // LR then SC succeeds
    for (int r = 0; r < 2; r++) begin
      base = (r != 0 ? BIU_BASE : DTCM_BASE) + 32'hC0;
      reserve(base);
      store_conditional(base, 32'hDEAD_BEEF);
      read_mem(base, LSU_SIZE_WORD, 1'b1);
    end

    // SC fails after a store, after a flush, and with no reservation
    base = DTCM_BASE + 32'h100;
    reserve(base);
    write_mem(base, 32'h0102_0304, 4'hF);
    store_conditional(base, 32'hCAFE_F00D);
    read_mem(base, LSU_SIZE_WORD, 1'b1);
    reserve(base);
    flush_commit();
    store_conditional(base, 32'hCAFE_F00D);
    read_mem(base, LSU_SIZE_WORD, 1'b1);
    store_conditional(base + 32'h4, 32'h7777_8888);
    read_mem(base + 32'h4, LSU_SIZE_WORD, 1'b1);

    // Bus error range
    read_mem(ERR_BASE + 32'h10, LSU_SIZE_WORD, 1'b0);
    write_mem(32'hF800_0000, 32'h1234_5678, 4'hF);

    // Random mix over a small window so reads hit earlier writes
    for (int n = 0; n < N_RAND; n++) begin
      base = ($urandom_range(0, 1) != 0) ? BIU_BASE : DTCM_BASE;
      addr = base + 32'h200 + $urandom_range(0, 31);
      issue_cmd(addr, $urandom_range(0, 1) != 0, $urandom, WMASK_W'($urandom),
                lsu_size_e'($urandom_range(0, 2)), $urandom_range(0, 7) == 0,
                $urandom_range(0, 1) != 0);
    end

    while (exp_q.size() != 0) begin
      @(posedge i_clk);
    end
    repeat (4) @(posedge i_clk);
    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

// ==== verif/lsu_tgt_model.sv ====
`timescale 1ns/1ps

module lsu_tgt_model import lsu_pkg::*; #(
  parameter int                AW       = ADDR_W,
  parameter bit                ERR_EN   = 1'b0,
  parameter logic [ADDR_W-1:0] ERR_BASE = 32'hF000_0000
) (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_cmd_valid,
  output logic               o_cmd_ready,
  input  logic [AW-1:0]      i_cmd_addr,
  input  logic               i_cmd_read,
  input  logic [XLEN-1:0]    i_cmd_wdata,
  input  logic [WMASK_W-1:0] i_cmd_wmask,
  output logic               o_rsp_valid,
  input  logic               i_rsp_ready,
  output logic               o_rsp_err,
  output logic [XLEN-1:0]    o_rsp_rdata
);

  // Sparse word store, keyed by the word-aligned local address
  logic [XLEN-1:0] mem [logic [ADDR_W-1:0]];

  // Pending responses in command order
  int unsigned     due_q [$];
  logic            err_q [$];
  logic [XLEN-1:0] data_q [$];
  int unsigned     cyc;

  // Unwritten words read back a pattern of their own address
  function automatic logic [XLEN-1:0] fill_word(input logic [ADDR_W-1:0] a);
    return (a * 32'h9E37_79B1) ^ 32'h5A3C_C3A5;
  endfunction

  initial begin
    o_cmd_ready = 1'b0;
    o_rsp_valid = 1'b0;
    o_rsp_err   = 1'b0;
    o_rsp_rdata = '0;
    cyc         = 0;
  end

  always @(posedge i_clk) begin : step
    logic [ADDR_W-1:0] key;
    logic [XLEN-1:0]   word;
    logic              err;
    if (i_reset) begin
      due_q.delete();
      err_q.delete();
      data_q.delete();
      cyc = 0;
    end else begin
      cyc++;
      if (o_rsp_valid && i_rsp_ready) begin
        void'(due_q.pop_front());
        void'(err_q.pop_front());
        void'(data_q.pop_front());
      end
      if (i_cmd_valid && o_cmd_ready) begin
        key  = ADDR_W'(i_cmd_addr) & ~ADDR_W'(3);
        err  = ERR_EN && (ADDR_W'(i_cmd_addr) >= ERR_BASE);
        word = mem.exists(key) ? mem[key] : fill_word(key);
        if (!i_cmd_read && !err) begin
          for (int b = 0; b < WMASK_W; b++) begin
            if (i_cmd_wmask[b]) begin
              word[8*b +: 8] = i_cmd_wdata[8*b +: 8];
            end
          end
          mem[key] = word;
        end
        data_q.push_back((i_cmd_read && !err) ? word : '0);
        err_q.push_back(err);
        // Earliest answer is in the cycle after acceptance
        due_q.push_back(cyc + $urandom_range(0, 3));
      end
    end
    #0.5;
    o_cmd_ready = ($urandom_range(0, 3) != 0);
    o_rsp_valid = (due_q.size() != 0) && (due_q[0] <= cyc);
    o_rsp_err   = o_rsp_valid ? err_q[0] : 1'b0;
    o_rsp_rdata = o_rsp_valid ? data_q[0] : '0;
  end

endmodule

// ==== src/lsu_ctrl_top.sv ====
`timescale 1ns/1ps

module lsu_ctrl_top import lsu_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_reset,
  input  logic                   i_commit_flush,

  input  logic                   i_agu_cmd_valid,
  output logic                   o_agu_cmd_ready,
  input  logic [ADDR_W-1:0]      i_agu_cmd_addr,
  input  logic                   i_agu_cmd_read,
  input  logic [XLEN-1:0]        i_agu_cmd_wdata,
  input  logic [WMASK_W-1:0]     i_agu_cmd_wmask,
  input  logic [1:0]             i_agu_cmd_size,
  input  logic                   i_agu_cmd_excl,
  input  logic                   i_agu_cmd_usign,
  input  logic [ITAG_W-1:0]      i_agu_cmd_itag,

  output logic                   o_dtcm_cmd_valid,
  input  logic                   i_dtcm_cmd_ready,
  output logic [DTCM_ADDR_W-1:0] o_dtcm_cmd_addr,
  output logic                   o_dtcm_cmd_read,
  output logic [XLEN-1:0]        o_dtcm_cmd_wdata,
  output logic [WMASK_W-1:0]     o_dtcm_cmd_wmask,
  output logic [1:0]             o_dtcm_cmd_size,
  input  logic                   i_dtcm_rsp_valid,
  output logic                   o_dtcm_rsp_ready,
  input  logic                   i_dtcm_rsp_err,
  input  logic [XLEN-1:0]        i_dtcm_rsp_rdata,

  output logic                   o_biu_cmd_valid,
  input  logic                   i_biu_cmd_ready,
  output logic [ADDR_W-1:0]      o_biu_cmd_addr,
  output logic                   o_biu_cmd_read,
  output logic [XLEN-1:0]        o_biu_cmd_wdata,
  output logic [WMASK_W-1:0]     o_biu_cmd_wmask,
  output logic [1:0]             o_biu_cmd_size,
  input  logic                   i_biu_rsp_valid,
  output logic                   o_biu_rsp_ready,
  input  logic                   i_biu_rsp_err,
  input  logic [XLEN-1:0]        i_biu_rsp_rdata,

  output logic                   o_lsu_valid,
  input  logic                   i_lsu_ready,
  output logic [XLEN-1:0]        o_lsu_wbck_wdat,
  output logic [ITAG_W-1:0]      o_lsu_wbck_itag,
  output logic                   o_lsu_wbck_err,
  output logic [ADDR_W-1:0]      o_lsu_cmt_badaddr,
  output logic                   o_lsu_cmt_ld,
  output logic                   o_lsu_cmt_st
);

  logic               push;
  lsu_outs_t          push_entry;
  logic               full;
  logic               head_valid;
  lsu_outs_t          head_entry;
  logic               pop;
  logic               cmd_accept;
  logic               scond_ok;
  logic [WMASK_W-1:0] wmask_pos;

  lsu_rsp_if rsp_if ();

  lsu_ctrl u_ctrl (
    .i_clk            (i_clk),
    .i_reset          (i_reset),
    .i_agu_cmd_valid  (i_agu_cmd_valid),
    .o_agu_cmd_ready  (o_agu_cmd_ready),
    .i_agu_cmd_addr   (i_agu_cmd_addr),
    .i_agu_cmd_read   (i_agu_cmd_read),
    .i_agu_cmd_wdata  (i_agu_cmd_wdata),
    .i_agu_cmd_size   (i_agu_cmd_size),
    .i_agu_cmd_excl   (i_agu_cmd_excl),
    .i_agu_cmd_usign  (i_agu_cmd_usign),
    .i_agu_cmd_itag   (i_agu_cmd_itag),
    .o_dtcm_cmd_valid (o_dtcm_cmd_valid),
    .i_dtcm_cmd_ready (i_dtcm_cmd_ready),
    .o_dtcm_cmd_addr  (o_dtcm_cmd_addr),
    .o_dtcm_cmd_read  (o_dtcm_cmd_read),
    .o_dtcm_cmd_wdata (o_dtcm_cmd_wdata),
    .o_dtcm_cmd_wmask (o_dtcm_cmd_wmask),
    .o_dtcm_cmd_size  (o_dtcm_cmd_size),
    .i_dtcm_rsp_valid (i_dtcm_rsp_valid),
    .o_dtcm_rsp_ready (o_dtcm_rsp_ready),
    .i_dtcm_rsp_err   (i_dtcm_rsp_err),
    .i_dtcm_rsp_rdata (i_dtcm_rsp_rdata),
    .o_biu_cmd_valid  (o_biu_cmd_valid),
    .i_biu_cmd_ready  (i_biu_cmd_ready),
    .o_biu_cmd_addr   (o_biu_cmd_addr),
    .o_biu_cmd_read   (o_biu_cmd_read),
    .o_biu_cmd_wdata  (o_biu_cmd_wdata),
    .o_biu_cmd_wmask  (o_biu_cmd_wmask),
    .o_biu_cmd_size   (o_biu_cmd_size),
    .i_biu_rsp_valid  (i_biu_rsp_valid),
    .o_biu_rsp_ready  (o_biu_rsp_ready),
    .i_biu_rsp_err    (i_biu_rsp_err),
    .i_biu_rsp_rdata  (i_biu_rsp_rdata),
    .o_push           (push),
    .o_push_entry     (push_entry),
    .i_full           (full),
    .i_head_valid     (head_valid),
    .i_head_entry     (head_entry),
    .o_pop            (pop),
    .o_cmd_accept     (cmd_accept),
    .i_scond_ok       (scond_ok),
    .i_wmask_pos      (wmask_pos),
    .rsp              (rsp_if.ctrl_mp)
  );

  lsu_outs_fifo u_outs_fifo (
    .i_clk        (i_clk),
    .i_reset      (i_reset),
    .i_push       (push),
    .i_push_entry (push_entry),
    .o_full       (full),
    .o_head_valid (head_valid),
    .o_head_entry (head_entry),
    .i_pop        (pop)
  );

  lsu_excl_monitor u_excl_monitor (
    .i_clk          (i_clk),
    .i_reset        (i_reset),
    .i_commit_flush (i_commit_flush),
    .i_cmd_accept   (cmd_accept),
    .i_cmd_addr     (i_agu_cmd_addr),
    .i_cmd_read     (i_agu_cmd_read),
    .i_cmd_excl     (i_agu_cmd_excl),
    .i_cmd_wmask    (i_agu_cmd_wmask),
    .o_scond_ok     (scond_ok),
    .o_wmask_pos    (wmask_pos)
  );

  lsu_wbck_fmt u_wbck_fmt (
    .rsp               (rsp_if.fmt_mp),
    .o_lsu_valid       (o_lsu_valid),
    .i_lsu_ready       (i_lsu_ready),
    .o_lsu_wbck_wdat   (o_lsu_wbck_wdat),
    .o_lsu_wbck_itag   (o_lsu_wbck_itag),
    .o_lsu_wbck_err    (o_lsu_wbck_err),
    .o_lsu_cmt_badaddr (o_lsu_cmt_badaddr),
    .o_lsu_cmt_ld      (o_lsu_cmt_ld),
    .o_lsu_cmt_st      (o_lsu_cmt_st)
  );

endmodule

// ==== src/lsu_wbck_fmt.sv ====
`timescale 1ns/1ps

module lsu_wbck_fmt import lsu_pkg::*; (
  lsu_rsp_if.fmt_mp          rsp,

  output logic               o_lsu_valid,
  input  logic               i_lsu_ready,
  output logic [XLEN-1:0]    o_lsu_wbck_wdat,
  output logic [ITAG_W-1:0]  o_lsu_wbck_itag,
  output logic               o_lsu_wbck_err,
  output logic [ADDR_W-1:0]  o_lsu_cmt_badaddr,
  output logic               o_lsu_cmt_ld,
  output logic               o_lsu_cmt_st
);

  logic [XLEN-1:0] rdata_algn;
  logic [XLEN-1:0] load_data;
  logic [XLEN-1:0] scond_wdat;
  logic            ext_b;
  logic            ext_h;

  // Bring the addressed byte lane down to bit 0
  assign rdata_algn = rsp.rdata >> {rsp.entry.addr[1:0], 3'b000};

  assign ext_b = ~rsp.entry.usign & rdata_algn[7];
  assign ext_h = ~rsp.entry.usign & rdata_algn[15];

  always_comb begin
    case (rsp.entry.size)
      LSU_SIZE_BYTE: load_data = {{(XLEN-8){ext_b}}, rdata_algn[7:0]};
      LSU_SIZE_HALF: load_data = {{(XLEN-16){ext_h}}, rdata_algn[15:0]};
      default:       load_data = rdata_algn;
    endcase
  end

  // RISC-V SC writes zero on success
  assign scond_wdat = rsp.scond_ok ? '0 : XLEN'(1);

  assign o_lsu_wbck_wdat = (~rsp.entry.read & rsp.entry.excl) ? scond_wdat : load_data;

  assign o_lsu_valid       = rsp.valid;
  assign rsp.ready         = i_lsu_ready;
  assign o_lsu_wbck_itag   = rsp.entry.itag;
  assign o_lsu_wbck_err    = rsp.err;
  assign o_lsu_cmt_badaddr = rsp.entry.addr;
  assign o_lsu_cmt_ld      = rsp.entry.read;
  assign o_lsu_cmt_st      = ~rsp.entry.read;

endmodule

// ==== src/lsu_ctrl.sv ====
`timescale 1ns/1ps

module lsu_ctrl import lsu_pkg::*; (
  input  logic                   i_clk,
  input  logic                   i_reset,

  // AGU command
  input  logic                   i_agu_cmd_valid,
  output logic                   o_agu_cmd_ready,
  input  logic [ADDR_W-1:0]      i_agu_cmd_addr,
  input  logic                   i_agu_cmd_read,
  input  logic [XLEN-1:0]        i_agu_cmd_wdata,
  input  logic [1:0]             i_agu_cmd_size,
  input  logic                   i_agu_cmd_excl,
  input  logic                   i_agu_cmd_usign,
  input  logic [ITAG_W-1:0]      i_agu_cmd_itag,

  // DTCM target
  output logic                   o_dtcm_cmd_valid,
  input  logic                   i_dtcm_cmd_ready,
  output logic [DTCM_ADDR_W-1:0] o_dtcm_cmd_addr,
  output logic                   o_dtcm_cmd_read,
  output logic [XLEN-1:0]        o_dtcm_cmd_wdata,
  output logic [WMASK_W-1:0]     o_dtcm_cmd_wmask,
  output logic [1:0]             o_dtcm_cmd_size,
  input  logic                   i_dtcm_rsp_valid,
  output logic                   o_dtcm_rsp_ready,
  input  logic                   i_dtcm_rsp_err,
  input  logic [XLEN-1:0]        i_dtcm_rsp_rdata,

  // BIU target
  output logic                   o_biu_cmd_valid,
  input  logic                   i_biu_cmd_ready,
  output logic [ADDR_W-1:0]      o_biu_cmd_addr,
  output logic                   o_biu_cmd_read,
  output logic [XLEN-1:0]        o_biu_cmd_wdata,
  output logic [WMASK_W-1:0]     o_biu_cmd_wmask,
  output logic [1:0]             o_biu_cmd_size,
  input  logic                   i_biu_rsp_valid,
  output logic                   o_biu_rsp_ready,
  input  logic                   i_biu_rsp_err,
  input  logic [XLEN-1:0]        i_biu_rsp_rdata,

  // Outstanding FIFO
  output logic                   o_push,
  output lsu_outs_t              o_push_entry,
  input  logic                   i_full,
  input  logic                   i_head_valid,
  input  lsu_outs_t              i_head_entry,
  output logic                   o_pop,

  // Reservation monitor
  output logic                   o_cmd_accept,
  input  logic                   i_scond_ok,
  input  logic [WMASK_W-1:0]     i_wmask_pos,

  lsu_rsp_if.ctrl_mp             rsp
);

  lsu_tgt_e cmd_tgt;
  logic     diff_tgt;
  logic     issue_ok;
  logic     cmd_accept;
  logic     head_dtcm;
  logic     head_biu;

  //////////////////////////////////////////////////
  // Command side

  assign cmd_tgt = (i_agu_cmd_addr[DTCM_REGION_HI:DTCM_REGION_LO] == DTCM_REGION_VAL) ?
                   LSU_TGT_DTCM : LSU_TGT_BIU;

  // Keep responses in order by never mixing targets in flight
  assign diff_tgt = i_head_valid & (i_head_entry.tgt != cmd_tgt);

  // Both readies are required so that ready does not wait on the decode
  assign issue_ok   = i_dtcm_cmd_ready & i_biu_cmd_ready & ~i_full & ~diff_tgt;
  assign cmd_accept = i_agu_cmd_valid & issue_ok;

  assign o_agu_cmd_ready = issue_ok;
  assign o_cmd_accept    = cmd_accept;
  assign o_push          = cmd_accept;

  assign o_dtcm_cmd_valid = cmd_accept & (cmd_tgt == LSU_TGT_DTCM);
  assign o_dtcm_cmd_addr  = i_agu_cmd_addr[DTCM_ADDR_W-1:0];
  assign o_dtcm_cmd_read  = i_agu_cmd_read;
  assign o_dtcm_cmd_wdata = i_agu_cmd_wdata;
  assign o_dtcm_cmd_wmask = i_wmask_pos;
  assign o_dtcm_cmd_size  = i_agu_cmd_size;

  assign o_biu_cmd_valid = cmd_accept & (cmd_tgt == LSU_TGT_BIU);
  assign o_biu_cmd_addr  = i_agu_cmd_addr;
  assign o_biu_cmd_read  = i_agu_cmd_read;
  assign o_biu_cmd_wdata = i_agu_cmd_wdata;
  assign o_biu_cmd_wmask = i_wmask_pos;
  assign o_biu_cmd_size  = i_agu_cmd_size;

  assign o_push_entry = '{
    tgt:      cmd_tgt,
    scond_ok: i_scond_ok,
    read:     i_agu_cmd_read,
    excl:     i_agu_cmd_excl,
    usign:    i_agu_cmd_usign,
    size:     lsu_size_e'(i_agu_cmd_size),
    itag:     i_agu_cmd_itag,
    addr:     i_agu_cmd_addr
  };

  //////////////////////////////////////////////////
  // Response side, steered by the oldest record

  assign head_dtcm = i_head_valid & (i_head_entry.tgt == LSU_TGT_DTCM);
  assign head_biu  = i_head_valid & (i_head_entry.tgt == LSU_TGT_BIU);

  assign rsp.valid    = (head_dtcm & i_dtcm_rsp_valid) | (head_biu & i_biu_rsp_valid);
  assign rsp.err      = head_biu ? i_biu_rsp_err : i_dtcm_rsp_err;
  assign rsp.rdata    = head_biu ? i_biu_rsp_rdata : i_dtcm_rsp_rdata;
  assign rsp.entry    = i_head_entry;
  assign rsp.scond_ok = i_head_entry.scond_ok;

  assign o_dtcm_rsp_ready = head_dtcm & rsp.ready;
  assign o_biu_rsp_ready  = head_biu & rsp.ready;
  assign o_pop            = rsp.valid & rsp.ready;

  a_one_target: assert property (@(posedge i_clk) disable iff (i_reset)
    !(o_dtcm_cmd_valid && o_biu_cmd_valid))
    else $error("Command issued to both targets");

  // A target answering with nothing in flight means a lost or extra response
  a_rsp_tracked: assert property (@(posedge i_clk) disable iff (i_reset)
    (i_dtcm_rsp_valid || i_biu_rsp_valid) |-> i_head_valid)
    else $error("Target response with empty outstanding FIFO");

endmodule

// ==== src/lsu_excl_monitor.sv ====
`timescale 1ns/1ps

module lsu_excl_monitor import lsu_pkg::*; (
  input  logic               i_clk,
  input  logic               i_reset,
  input  logic               i_commit_flush,
  input  logic               i_cmd_accept,
  input  logic [ADDR_W-1:0]  i_cmd_addr,
  input  logic               i_cmd_read,
  input  logic               i_cmd_excl,
  input  logic [WMASK_W-1:0] i_cmd_wmask,
  output logic               o_scond_ok,
  output logic [WMASK_W-1:0] o_wmask_pos
);

  logic              excl_flg_r;
  logic [ADDR_W-1:0] excl_addr_r;
  logic              addr_match;
  logic              flg_set;
  logic              flg_clr;
  logic              is_scond;

  assign addr_match = (i_cmd_addr == excl_addr_r);
  assign is_scond   = i_cmd_excl & ~i_cmd_read;

  // Load-reserved arms, any write that hits the reservation disarms
  assign flg_set = i_cmd_accept & i_cmd_read & i_cmd_excl;
  assign flg_clr = (i_cmd_accept & ~i_cmd_read & addr_match & excl_flg_r) | i_commit_flush;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      excl_flg_r <= 1'b0;
    end else if (flg_set) begin
      excl_flg_r <= 1'b1;
    end else if (flg_clr) begin
      excl_flg_r <= 1'b0;
    end
  end

  always_ff @(posedge i_clk) begin
    if (flg_set) begin
      excl_addr_r <= i_cmd_addr;
    end
  end

  assign o_scond_ok = is_scond & excl_flg_r & addr_match;

  // Failed store-conditional must not touch memory
  assign o_wmask_pos = (is_scond & ~o_scond_ok) ? '0 : i_cmd_wmask;

endmodule

// ==== src/lsu_outs_fifo.sv ====
`timescale 1ns/1ps

module lsu_outs_fifo import lsu_pkg::*; (
  input  logic      i_clk,
  input  logic      i_reset,
  input  logic      i_push,
  input  lsu_outs_t i_push_entry,
  output logic      o_full,
  output logic      o_head_valid,
  output lsu_outs_t o_head_entry,
  input  logic      i_pop
);

  lsu_outs_t                       entries [OUTS_NUM];
  logic [$clog2(OUTS_NUM)-1:0]     wr_ptr;
  logic [$clog2(OUTS_NUM)-1:0]     rd_ptr;
  logic [$clog2(OUTS_NUM+1)-1:0]   count;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= (wr_ptr == OUTS_NUM - 1) ? '0 : wr_ptr + 1'b1;
      end
      if (i_pop) begin
        rd_ptr <= (rd_ptr == OUTS_NUM - 1) ? '0 : rd_ptr + 1'b1;
      end
      case ({i_push, i_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_push) begin
      entries[wr_ptr] <= i_push_entry;
    end
  end

  assign o_full       = (count == OUTS_NUM);
  assign o_head_valid = (count != 0);

  // Head fields act as control downstream, so hide stale records
  assign o_head_entry = o_head_valid ? entries[rd_ptr] : '0;

  a_no_ovf_udf: assert property (@(posedge i_clk) disable iff (i_reset)
    !(i_push && o_full && !i_pop) && !(i_pop && !o_head_valid))
    else $error("Outstanding FIFO overflow or underflow");

endmodule

// ==== src/lsu_rsp_if.sv ====
`timescale 1ns/1ps

// Response selected by the control, with the record of the access it answers
interface lsu_rsp_if import lsu_pkg::*; ();

  logic            valid;
  logic            ready;
  logic            err;
  logic [XLEN-1:0] rdata;
  lsu_outs_t       entry;
  logic            scond_ok;

  modport ctrl_mp (
    output valid,
    output err,
    output rdata,
    output entry,
    output scond_ok,
    input  ready
  );

  modport fmt_mp (
    input  valid,
    input  err,
    input  rdata,
    input  entry,
    input  scond_ok,
    output ready
  );

endinterface

// ==== src/lsu_pkg.sv ====
package lsu_pkg;

  //////////////////////////////////////////////////
  // Data path widths
  localparam int XLEN    = 32;
  localparam int ADDR_W  = 32;
  localparam int WMASK_W = XLEN / 8;
  localparam int ITAG_W  = 2;

  //////////////////////////////////////////////////
  // DTCM region decode
  localparam int DTCM_ADDR_W    = 16;
  localparam int DTCM_REGION_HI = 31;
  localparam int DTCM_REGION_LO = 16;
  localparam logic [DTCM_REGION_HI-DTCM_REGION_LO:0] DTCM_REGION_VAL = 16'h8000;

  // Depth of the outstanding tracker
  localparam int OUTS_NUM = 2;

  // Access size as carried on the command bus
  typedef enum logic [1:0] {
    LSU_SIZE_BYTE = 2'b00,
    LSU_SIZE_HALF = 2'b01,
    LSU_SIZE_WORD = 2'b10
  } lsu_size_e;

  typedef enum logic {
    LSU_TGT_DTCM = 1'b0,
    LSU_TGT_BIU  = 1'b1
  } lsu_tgt_e;

  // One in-flight access, kept until its response returns
  typedef struct packed {
    lsu_tgt_e              tgt;
    logic                  scond_ok;
    logic                  read;
    logic                  excl;
    logic                  usign;
    lsu_size_e             size;
    logic [ITAG_W-1:0]     itag;
    logic [ADDR_W-1:0]     addr;
  } lsu_outs_t;

endpackage
